// ==== tb.f ====
hdl/adc_pkg.sv
hdl/adc_sequencer.sv
hdl/adc_serial_port.sv
hdl/sample_bank.sv
hdl/adc_driver.sv
sim/adc_model.sv
sim/tb_adc_driver.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the adc driver testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_driver -f tb.f

output=$(./obj_dir/Vtb_adc_driver 2>&1 || true)
echo "$output"
grep -qx "Simulation completed successfully" <<< "$output"

// ==== sim/tb_adc_driver.sv ====
`timescale 1ns/1ns

module tb_adc_driver import adc_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int SEED = 32'h4dbf_3e43;
	// 12 sample periods plus one configuration pass per start
	localparam int WATCHDOG_CYCLES = 12 * SAMPLE_PERIOD_CYCLES + 2 * NUM_CHANNELS * FRAME_CYCLES;
	localparam logic [6:0] RESET_STATUS = 7'b100_0000;   // cs_n high, rest low
	localparam logic [2:0] STOP_STATUS = 3'b100;         // cs_n high, not busy

	logic    clk = 1'b0;
	logic    rst;
	logic    start;
	logic    stop_sampling;
	logic    dout;
	logic    cs_n;
	logic    sclk;
	logic    din;
	logic    config_busy;
	logic    sampling_busy;
	sample_t ch_value [NUM_CHANNELS];
	logic    sample_updated;

	int        model_bits;
	cmd_word_t model_cmd;
	sample_t   last_sent [NUM_CHANNELS];

	int   cycle_cnt;
	int   bits_q;                                  // model bit count one clock ago
	int   frame_idx;                               // frames decoded since start
	int   low_cycles;                              // clocks with cs_n low
	int   gap;                                     // clocks since the last update
	bit   prev_seen;
	logic cmd_new;
	logic [NUM_CHANNELS*DATA_BITS-1:0] published;
	logic [NUM_CHANNELS*DATA_BITS-1:0] published_q;   // outputs one clock ago
	logic [NUM_CHANNELS*DATA_BITS-1:0] expected_values;
	logic [CMD_BITS+1:0] got_frame;
	logic [CMD_BITS+1:0] exp_frame;
	logic [6:0] rst_status;
	logic [2:0] stop_status;

	always #(CLK_PERIOD / 2) clk = ~clk;

	adc_driver i_dut (.*);

	adc_model i_adc (
		.cs_n      (cs_n),
		.sclk      (sclk),
		.din       (din),
		.dout      (dout),
		.n_bits    (model_bits),
		.cmd       (model_cmd),
		.last_sent (last_sent)
	);

	// --------------------------------------------------
	// expected values and reporting
	// --------------------------------------------------

	// start bit, code, single ended, range only in the first three frames
	function automatic cmd_word_t expected_cmd(int idx);
		chan_code_t  code;
		range_code_t range;
		code = chan_code_t'(idx % NUM_CHANNELS);
		range = (idx < NUM_CHANNELS) ? CFG_RANGE : 3'b000;
		return {1'b1, code, 1'b0, range};
	endfunction

	task automatic stop_run(string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(string test, logic [63:0] expected, logic [63:0] actual);
		stop_run($sformatf("Fail %s: expected %0h, actual %0h", test, expected, actual));
	endtask

	assign cmd_new = (model_bits == CMD_BITS) && (bits_q != CMD_BITS);
	assign got_frame = {model_cmd, config_busy, sampling_busy};
	assign exp_frame = {expected_cmd(frame_idx), frame_idx < NUM_CHANNELS,
		frame_idx >= NUM_CHANNELS};
	assign published = {ch_value[2], ch_value[1], ch_value[0]};
	assign expected_values = {last_sent[2], last_sent[1], last_sent[0]};
	assign rst_status = {cs_n, sclk, din, config_busy, sampling_busy, sample_updated,
		published != '0};
	assign stop_status = {cs_n, config_busy, sampling_busy};

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		bits_q <= model_bits;
		published_q <= published;
		low_cycles <= cs_n ? 0 : low_cycles + 1;
		if (start)
			frame_idx <= 0;                        // new run, config frames first
		else if (cmd_new)
			frame_idx <= frame_idx + 1;
		if (rst || stop_sampling)
		begin
			prev_seen <= 1'b0;                     // period restarts after a stop
			gap <= 0;
		end
		else if (sample_updated)
		begin
			prev_seen <= 1'b1;
			gap <= 1;
		end
		else
			gap <= gap + 1;
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	a_reset_state: assert property (@(posedge clk)
		(cycle_cnt > 0 && $past(rst)) |-> rst_status == RESET_STATUS)
		else report_mismatch("reset state", 64'(RESET_STATUS), 64'($sampled(rst_status)));

	a_frame_cmd: assert property (@(posedge clk) disable iff (rst)
		cmd_new |-> got_frame == exp_frame)
		else report_mismatch("frame command", 64'($sampled(exp_frame)),
			64'($sampled(got_frame)));

	a_frame_len: assert property (@(posedge clk) disable iff (rst)
		($rose(cs_n) && !$past(stop_sampling)) |-> low_cycles == 2 * FRAME_BITS)
		else report_mismatch("frame length", 64'(2 * FRAME_BITS), 64'($sampled(low_cycles)));

	a_published: assert property (@(posedge clk) disable iff (rst)
		sample_updated |-> published == expected_values)
		else report_mismatch("published values", 64'($sampled(expected_values)),
			64'($sampled(published)));

	a_period: assert property (@(posedge clk) disable iff (rst)
		(sample_updated && prev_seen) |-> gap == SAMPLE_PERIOD_CYCLES)
		else report_mismatch("sample period", 64'(SAMPLE_PERIOD_CYCLES), 64'($sampled(gap)));

	a_stop_state: assert property (@(posedge clk) disable iff (rst)
		$past(stop_sampling) |-> stop_status == STOP_STATUS)
		else report_mismatch("stop state", 64'(STOP_STATUS), 64'($sampled(stop_status)));

	a_hold: assert property (@(posedge clk) disable iff (rst)
		!sample_updated |-> published == published_q)
		else report_mismatch("hold outputs", 64'($sampled(published_q)),
			64'($sampled(published)));

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------

	// one start pulse, then wait for a number of published rounds
	task automatic collect_rounds(int pulses);
		int seen;
		seen = 0;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (seen < pulses)
		begin
			@(posedge clk);
			if (sample_updated)
				seen++;
		end
	endtask

	initial
	begin
		void'($urandom(SEED));
		rst = 1'b1;
		start = 1'b0;
		stop_sampling = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk);
		collect_rounds(4);
		repeat (60 + $urandom % 120) @(posedge clk);   // mostly lands inside a frame
		stop_sampling <= 1'b1;
		@(posedge clk);
		stop_sampling <= 1'b0;
		repeat (30) @(posedge clk);                    // idle, outputs hold
		collect_rounds(3);                             // config again, then sampling
		repeat (5) @(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_run($sformatf("Timeout, run not finished after %0d cycles", WATCHDOG_CYCLES));
	end

endmodule

// ==== sim/adc_model.sv ====
`timescale 1ns/1ns

module adc_model import adc_pkg::*;
(
	input  logic      cs_n,
	input  logic      sclk,
	input  logic      din,
	output logic      dout,
	output int        n_bits,                      // sclk rises seen in this frame
	output cmd_word_t cmd,                         // decoded after the 8th rise
	output sample_t   last_sent [NUM_CHANNELS]     // indexed by channel code
);

	cmd_word_t shift_in;                           // din bits, msb first
	sample_t   reply;                              // answer for the current frame
	sample_t   reply_sr;
	logic      sampling;                           // range 0, answer with data

	initial
	begin
		dout = 1'b0;
		n_bits = 0;
		sampling = 1'b0;
		for (int i = 0; i < NUM_CHANNELS; i++)
			last_sent[i] = '0;
	end

	// --------------------------------------------------
	// command side, din latched on rising sclk
	// --------------------------------------------------

	always @(negedge cs_n or posedge sclk)
	begin
		cmd_word_t word;
		word = {shift_in[CMD_BITS-2:0], din};
		if (!sclk)
			n_bits <= 0;                           // chip select just fell
		else if (!cs_n)
		begin
			shift_in <= word;
			n_bits <= n_bits + 1;
			if (n_bits == CMD_BITS - 1)
			begin
				cmd <= word;
				// start bit set and range bits zero make a sample request
				sampling <= word[CMD_BITS-1] && (word[2:0] == 3'b000);
				reply <= sample_t'($urandom);
			end
			// whole reply shifted out, remember it per channel code
			if (n_bits == FRAME_BITS - 1 && sampling)
				for (int i = 0; i < NUM_CHANNELS; i++)
					if (cmd[6:4] == chan_code_t'(i))
						last_sent[i] <= reply;
		end
	end

	// --------------------------------------------------
	// reply side, dout changes on falling sclk
	// --------------------------------------------------

	always @(negedge sclk)
	begin
		if (sampling && n_bits == CMD_BITS)
		begin
			dout <= reply[DATA_BITS-1];            // first data bit, msb
			reply_sr <= {reply[DATA_BITS-2:0], 1'b0};
		end
		else if (sampling && n_bits > CMD_BITS && n_bits < FRAME_BITS)
		begin
			dout <= reply_sr[DATA_BITS-1];
			reply_sr <= {reply_sr[DATA_BITS-2:0], 1'b0};
		end
		else
			dout <= 1'b0;                          // config frames and gaps
	end

endmodule

// ==== hdl/adc_driver.sv ====
`timescale 1ns/1ns

module adc_driver import adc_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    start,                      // config then sample
	input  logic    stop_sampling,              // abort and go idle
	input  logic    dout,                       // adc serial out
	output logic    cs_n,
	output logic    sclk,
	output logic    din,                        // adc serial in
	output logic    config_busy,
	output logic    sampling_busy,
	output sample_t ch_value [NUM_CHANNELS],
	output logic    sample_updated
);

	// --------------------------------------------------
	// internal links
	// --------------------------------------------------

	logic       req_valid;
	frame_req_t req;
	logic       port_busy;
	logic       frame_done;
	logic       rsp_valid;
	frame_rsp_t rsp;
	logic       publish;

	// frame requests and run state
	adc_sequencer i_sequencer (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.stop          (stop_sampling),
		.busy          (port_busy),
		.done          (frame_done),
		.req_valid     (req_valid),
		.req           (req),
		.publish       (publish),
		.config_busy   (config_busy),
		.sampling_busy (sampling_busy)
	);

	// wire protocol
	adc_serial_port i_port (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.abort     (stop_sampling),
		.dout      (dout),
		.busy      (port_busy),
		.done      (frame_done),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.cs_n      (cs_n),
		.sclk      (sclk),
		.din       (din)
	);

	// result staging and publish
	sample_bank i_bank (
		.clk            (clk),
		.rst            (rst),
		.rsp_valid      (rsp_valid),
		.rsp            (rsp),
		.publish        (publish),
		.ch_value       (ch_value),
		.sample_updated (sample_updated)
	);

endmodule

// ==== hdl/sample_bank.sv ====
`timescale 1ns/1ns

module sample_bank import adc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       rsp_valid,                // result of a sample frame
	input  frame_rsp_t rsp,
	input  logic       publish,                  // round done, copy to outputs
	output sample_t    ch_value [NUM_CHANNELS],  // last published round
	output logic       sample_updated            // one clock after publish
);

	sample_t stage [NUM_CHANNELS];               // results of the current round

	// --------------------------------------------------
	// staging by slot
	// --------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (rsp_valid)
			for (int i = 0; i < NUM_CHANNELS; i++)
				if (rsp.slot == slot_t'(i))
					stage[i] <= rsp.data;
	end

	// --------------------------------------------------
	// published outputs
	// --------------------------------------------------

	// all channels change together, outputs hold between rounds
	always_ff @(posedge clk)
	begin
		sample_updated <= 1'b0;
		if (rst)
		begin
			for (int i = 0; i < NUM_CHANNELS; i++)
				ch_value[i] <= '0;
		end
		else if (publish)
		begin
			ch_value <= stage;
			sample_updated <= 1'b1;
		end
	end

	// publish comes a clock after the last done, never with a result
	a_no_rsp_on_publish: assert property (@(posedge clk) disable iff (rst)
		!(rsp_valid && publish));

	// results only ever name a scanned slot
	a_rsp_slot_range: assert property (@(posedge clk) disable iff (rst)
		rsp_valid |-> (rsp.slot <= LAST_SLOT));

endmodule

// ==== hdl/adc_serial_port.sv ====
`timescale 1ns/1ns

module adc_serial_port import adc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       req_valid,        // sampled only when idle
	input  frame_req_t req,
	input  logic       abort,            // drop the frame, no done
	input  logic       dout,             // serial data from the adc
	output logic       busy,
	output logic       done,             // one clock at frame end
	output logic       rsp_valid,        // with done, sample frames only
	output frame_rsp_t rsp,
	output logic       cs_n,
	output logic       sclk,             // half the clock rate while shifting
	output logic       din
);

	localparam int CNT_W = $clog2(FRAME_BITS);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_BITS - 1);
	localparam logic [CNT_W-1:0] FIRST_DATA_BIT = CNT_W'(CMD_BITS);

	port_state_t      state;
	logic [CNT_W-1:0] bit_cnt;           // bit on the wire, 0..23
	logic             phase;             // set in the sclk high half
	cmd_word_t        cmd_sr;            // bits still to go out on din
	sample_t          data_sr;           // result, msb shifted in first
	slot_t            slot_q;            // slot of the frame in flight
	logic             capture_q;

	// --------------------------------------------------
	// frame control
	// --------------------------------------------------

	// each bit takes two clocks, sclk low then high
	always_ff @(posedge clk)
	begin
		done <= 1'b0;
		rsp_valid <= 1'b0;
		if (rst || abort)
		begin
			state <= PORT_IDLE;
			cs_n <= 1'b1;                 // bus inactive next clock
			sclk <= 1'b0;
			din <= 1'b0;
			bit_cnt <= '0;
			phase <= 1'b0;
		end
		else
		begin
			case (state)
			PORT_IDLE:
				if (req_valid)
				begin
					state <= PORT_SHIFT;
					cs_n <= 1'b0;
					bit_cnt <= '0;
					phase <= 1'b0;
					din <= req.cmd[CMD_BITS-1];    // start bit with cs low
				end
			PORT_SHIFT:
				if (!phase)
				begin
					sclk <= 1'b1;             // rising sclk, adc latches din
					phase <= 1'b1;
				end
				else if (bit_cnt == LAST_BIT)
				begin
					// last high half over, release the bus
					state <= PORT_DONE;
					cs_n <= 1'b1;
					sclk <= 1'b0;
					din <= 1'b0;
					done <= 1'b1;
					rsp_valid <= capture_q;
				end
				else
				begin
					sclk <= 1'b0;
					phase <= 1'b0;
					bit_cnt <= bit_cnt + 1'b1;
					din <= cmd_sr[CMD_BITS-1];     // zeros once the command is out
				end
			PORT_DONE:
				state <= PORT_IDLE;           // one clock so the next req lands in idle
			default:
				state <= PORT_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// shift registers
	// --------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (state == PORT_IDLE && req_valid)
		begin
			cmd_sr <= {req.cmd[CMD_BITS-2:0], 1'b0};  // msb already on din
			slot_q <= req.slot;
			capture_q <= req.capture;
		end
		else if (state == PORT_SHIFT && phase)
			cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b0};
		// dout sampled on the edge that raises sclk, data bits only
		if (state == PORT_SHIFT && !phase && bit_cnt >= FIRST_DATA_BIT)
			data_sr <= {data_sr[DATA_BITS-2:0], dout};
	end

	assign busy = (state != PORT_IDLE);
	assign rsp = '{slot: slot_q, data: data_sr};

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// chip select held low across every shifted bit
	a_cs_frame: assert property (@(posedge clk) disable iff (rst)
		(state == PORT_SHIFT) |-> !cs_n);

	// done is a single clock pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done);

endmodule

// ==== hdl/adc_sequencer.sv ====
`timescale 1ns/1ns

module adc_sequencer import adc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,            // begin config, then sampling
	input  logic       stop,             // back to idle from any state
	input  logic       busy,             // serial port has a frame in flight
	input  logic       done,             // end of frame from the port
	output logic       req_valid,        // one clock strobe with req
	output frame_req_t req,
	output logic       publish,          // one clock strobe, staged values to outputs
	output logic       config_busy,
	output logic       sampling_busy
);

	localparam int WAIT_W = $clog2(WAIT_CYCLES + 1);

	run_state_t        state;
	slot_t             slot;             // slot of the frame in flight
	slot_t             next_slot;
	logic [WAIT_W-1:0] wait_cnt;         // clocks left in RUN_WAIT

	// --------------------------------------------------
	// command builder
	// --------------------------------------------------

	// config frames carry the range, sample frames carry range 0 and capture
	function automatic frame_req_t make_req(slot_t s, logic cfg);
		frame_req_t r;
		r.cmd = {1'b1, CHAN_CODES[s], 1'b0, cfg ? CFG_RANGE : SAMPLE_RANGE};
		r.slot = s;
		r.capture = !cfg;
		return r;
	endfunction

	assign next_slot = slot + slot_t'(1);

	// --------------------------------------------------
	// run state machine
	// --------------------------------------------------

	// every request is registered on the done edge, so it lands
	// one clock after done, when the port has just gone idle
	always_ff @(posedge clk)
	begin
		req_valid <= 1'b0;               // strobes
		publish <= 1'b0;
		if (rst || stop)
		begin
			state <= RUN_IDLE;
			slot <= '0;
			wait_cnt <= '0;
		end
		else
		begin
			case (state)
			RUN_IDLE:
				if (start && !busy)
				begin
					state <= RUN_CONFIG;
					slot <= '0;
					req_valid <= 1'b1;    // first config frame next clock
					req <= make_req('0, 1'b1);
				end
			RUN_CONFIG:
				if (done)
				begin
					req_valid <= 1'b1;
					if (slot == LAST_SLOT)
					begin
						// all ranges set, start the first round
						state <= RUN_SAMPLE;
						slot <= '0;
						req <= make_req('0, 1'b0);
					end
					else
					begin
						slot <= next_slot;
						req <= make_req(next_slot, 1'b1);
					end
				end
			RUN_SAMPLE:
				if (done)
				begin
					if (slot == LAST_SLOT)
					begin
						state <= RUN_WAIT;
						publish <= 1'b1;      // round complete
						wait_cnt <= WAIT_W'(WAIT_CYCLES - 1);
					end
					else
					begin
						slot <= next_slot;
						req_valid <= 1'b1;
						req <= make_req(next_slot, 1'b0);
					end
				end
			RUN_WAIT:
				if (wait_cnt == '0)
				begin
					// slot 0 request lands SAMPLE_PERIOD_CYCLES after the last one
					state <= RUN_SAMPLE;
					slot <= '0;
					req_valid <= 1'b1;
					req <= make_req('0, 1'b0);
				end
				else
					wait_cnt <= wait_cnt - 1'b1;
			default:
				state <= RUN_IDLE;
			endcase
		end
	end

	// status levels
	assign config_busy = (state == RUN_CONFIG);
	assign sampling_busy = (state == RUN_SAMPLE) || (state == RUN_WAIT);

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// the port never gets a request while its previous frame is still running
	a_req_port_free: assert property (@(posedge clk) disable iff (rst)
		req_valid |-> !busy);

endmodule

// ==== hdl/adc_pkg.sv ====
package adc_pkg;

	// --------------------------------------------------
	// scan and frame geometry
	// --------------------------------------------------

	localparam int NUM_CHANNELS = 3;                      // channels scanned each round
	localparam int CMD_BITS = 8;                          // command word, start bit goes first
	localparam int DATA_BITS = 16;                        // conversion result width
	localparam int FRAME_BITS = CMD_BITS + DATA_BITS;     // sclk periods per frame

	// accepted request to the next possible request
	// 2 clocks per bit, one clock cs high with done, one idle clock
	localparam int FRAME_CYCLES = 2 * FRAME_BITS + 2;

	localparam int SAMPLE_PERIOD_CYCLES = 200;            // clocks between sample_updated pulses

	// idle clocks after the last frame of a round, keeps rounds on the period grid
	localparam int WAIT_CYCLES = SAMPLE_PERIOD_CYCLES - NUM_CHANNELS * FRAME_CYCLES;

	// --------------------------------------------------
	// widths with a meaning
	// --------------------------------------------------

	typedef logic [CMD_BITS-1:0] cmd_word_t;      // start, C2..C0, DIF, R2..R0 (msb first)
	typedef logic [DATA_BITS-1:0] sample_t;       // raw adc code
	typedef logic [2:0] chan_code_t;              // C2..C0
	typedef logic [2:0] range_code_t;             // R2..R0
	typedef logic [1:0] slot_t;                   // scan position 0..2

	// channel code sent for each scan slot
	localparam chan_code_t CHAN_CODES [NUM_CHANNELS] = '{3'd0, 3'd1, 3'd2};

	localparam range_code_t CFG_RANGE = 3'b110;       // 0 to 6.1 V input range
	localparam range_code_t SAMPLE_RANGE = 3'b000;    // range bits stay zero when sampling
	localparam slot_t LAST_SLOT = slot_t'(NUM_CHANNELS - 1);

	// --------------------------------------------------
	// bundles between the blocks
	// --------------------------------------------------

	// one frame for the serial port
	typedef struct packed {
		cmd_word_t cmd;         // command shifted out on din
		slot_t     slot;        // scan slot, returned with the result
		logic      capture;     // sample frame, result goes to the bank
	} frame_req_t;

	// result of a sample frame
	typedef struct packed {
		slot_t   slot;
		sample_t data;
	} frame_rsp_t;

	// --------------------------------------------------
	// state machines
	// --------------------------------------------------

	typedef enum logic [1:0] {
		RUN_IDLE,
		RUN_CONFIG,
		RUN_SAMPLE,
		RUN_WAIT
	} run_state_t;

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_SHIFT,
		PORT_DONE
	} port_state_t;

endpackage
